// ==== wht_defs.svh ====
//--------------------------------------
// Sizes and fixed-point positions for the luma DC path
// Included by the packages and by any module that needs a width
//--------------------------------------
`ifndef WHT_DEFS_SVH
`define WHT_DEFS_SVH

// Block geometry
`define WHT_BLOCK_SIZE 4
`define WHT_NUM_COEF   16

// Coefficient and level widths
`define DC_WIDTH       12
`define WHT_WIDTH      15
`define LEVEL_WIDTH    12

// Quantizer step and reciprocal precision
`define QSTEP_WIDTH    8
`define QRECIP_SHIFT   17

`endif

// ==== coef_pkg.sv ====
//--------------------------------------
// Coefficient types of the DC transform datapath
//--------------------------------------
`include "wht_defs.svh"

package coef_pkg;

    // One DC term per 4x4 luma block
    typedef logic signed [`DC_WIDTH-1:0] dc_coef_t;

    // WHT output after halving
    typedef logic signed [`WHT_WIDTH-1:0] wht_coef_t;

    // Raster order, index = row * 4 + column
    typedef dc_coef_t dc_block_t [0:`WHT_NUM_COEF-1];

    // Same layout as the input block
    typedef wht_coef_t wht_block_t [0:`WHT_NUM_COEF-1];

endpackage

// ==== quant_pkg.sv ====
//--------------------------------------
// Quantizer types for step, reciprocal and output level
//--------------------------------------
`include "wht_defs.svh"

package quant_pkg;

    // Step size, zero is not legal
    typedef logic [`QSTEP_WIDTH-1:0] qstep_t;

    // floor(2^17 / step) needs one bit above the shift for step 1
    typedef logic [`QRECIP_SHIFT:0] qrecip_t;

    // Signed level, saturated to +/-2047
    typedef logic signed [`LEVEL_WIDTH-1:0] level_t;

    typedef level_t level_block_t [0:`WHT_NUM_COEF-1];

endpackage

// ==== dc_collector.sv ====
//--------------------------------------
// Gathers sixteen strobed DC terms into one 4x4 block
// Pulses start_o one cycle after the 16th strobe
//--------------------------------------
`timescale 1ns/1ns
`include "wht_defs.svh"

module dc_collector
    import coef_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dc_valid_i,
    input  dc_coef_t  dc_i,
    output logic      start_o,
    output dc_block_t block_o
);

    localparam int POS_W = $clog2(`WHT_NUM_COEF);
    localparam int LAST  = `WHT_NUM_COEF - 1;
    localparam logic [POS_W-1:0] LAST_POS = LAST[POS_W-1:0];

    logic [POS_W-1:0] pos_q;           // Raster slot of the next strobe
    dc_coef_t         shadow_q [0:LAST-1];
    logic             last_strobe;

    assign last_strobe = dc_valid_i && (pos_q == LAST_POS);

    // Fill side, the last term goes straight to the output
    always_ff @(posedge clk) begin
        if (dc_valid_i && (pos_q != LAST_POS)) begin
            shadow_q[pos_q] <= dc_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_q   <= '0;
            start_o <= 1'b0;
        end else begin
            start_o <= last_strobe;
            if (dc_valid_i) begin
                pos_q <= pos_q + 1'b1;     // Wraps to 0 after slot 15
            end
        end
    end

    // Hand-off copy so the shadow can refill at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WHT_NUM_COEF; i++) begin
                block_o[i] <= '0;
            end
        end else if (last_strobe) begin
            for (int i = 0; i < LAST; i++) begin
                block_o[i] <= shadow_q[i];
            end
            block_o[LAST] <= dc_i;
        end
    end

    // A block needs sixteen strobes, so starts are never adjacent
    a_start_single : assert property (@(posedge clk) disable iff (!rst_n)
        start_o |=> !start_o);

endmodule

// ==== wht_fwd.sv ====
//--------------------------------------
// Forward 4x4 Walsh-Hadamard transform with halving
// Output registered on start_i and done_o one cycle later
//--------------------------------------
`timescale 1ns/1ns
`include "wht_defs.svh"

module wht_fwd
    import coef_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  dc_block_t  block_i,
    output logic       done_o,
    output wht_block_t block_o
);

    localparam int N = `WHT_BLOCK_SIZE;

    logic signed [`DC_WIDTH+1:0] row_q  [0:`WHT_NUM_COEF-1];  // 14b row results
    wht_coef_t                   wht_nxt[0:`WHT_NUM_COEF-1];
    logic signed [`WHT_WIDTH:0]  dc_sum;                       // Plain sum of all inputs

    // ---------------------------------------
    // Row pass
    // ---------------------------------------
    for (genvar r = 0; r < N; r++) begin : g_row
        logic signed [`DC_WIDTH:0] a0, a1, a2, a3;   // 13b

        assign a0 = block_i[N*r+0] + block_i[N*r+2];
        assign a1 = block_i[N*r+1] + block_i[N*r+3];
        assign a2 = block_i[N*r+1] - block_i[N*r+3];
        assign a3 = block_i[N*r+0] - block_i[N*r+2];

        assign row_q[N*r+0] = a0 + a1;
        assign row_q[N*r+1] = a3 + a2;
        assign row_q[N*r+2] = a3 - a2;
        assign row_q[N*r+3] = a0 - a1;
    end

    // ---------------------------------------
    // Column pass and halving
    // ---------------------------------------
    for (genvar c = 0; c < N; c++) begin : g_col
        logic signed [`WHT_WIDTH-1:0] b0, b1, b2, b3;  // 15b
        logic signed [`WHT_WIDTH:0]   s [0:N-1];       // Full 16b sums

        assign b0 = row_q[c]       + row_q[2*N+c];
        assign b1 = row_q[N+c]     + row_q[3*N+c];
        assign b2 = row_q[N+c]     - row_q[3*N+c];
        assign b3 = row_q[c]       - row_q[2*N+c];

        assign s[0] = b0 + b1;
        assign s[1] = b3 + b2;
        assign s[2] = b3 - b2;
        assign s[3] = b0 - b1;

        // Dropping bit 0 of the signed sum gives floor of half
        for (genvar k = 0; k < N; k++) begin : g_half
            assign wht_nxt[N*k+c] = s[k][`WHT_WIDTH:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
            for (int i = 0; i < `WHT_NUM_COEF; i++) begin
                block_o[i] <= '0;
            end
        end else begin
            done_o <= start_i;
            if (start_i) begin
                block_o <= wht_nxt;     // Held until the next block
            end
        end
    end

    always_comb begin
        dc_sum = '0;
        for (int i = 0; i < `WHT_NUM_COEF; i++) begin
            dc_sum = dc_sum + block_i[i];
        end
    end

    // DC term of the butterflies equals half the total of the block
    a_dc_half_sum : assert property (@(posedge clk) disable iff (!rst_n)
        start_i |=> (block_o[0] == wht_coef_t'($past(dc_sum) >>> 1)));

endmodule

// ==== dc_quantizer.sv ====
//--------------------------------------
// Reciprocal divider and sixteen parallel quantizer lanes
// Load a step, wait for q_ready_o, then feed transform blocks
//--------------------------------------
`timescale 1ns/1ns
`include "wht_defs.svh"

module dc_quantizer
    import coef_pkg::*, quant_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         q_load_i,
    input  qstep_t       q_step_i,
    output logic         q_ready_o,
    input  logic         valid_i,
    input  wht_block_t   block_i,
    output logic         valid_o,
    output level_block_t levels_o
);

    localparam int CNT_W  = $clog2(`QRECIP_SHIFT + 1);
    localparam int PROD_W = `WHT_WIDTH + `QRECIP_SHIFT + 1;
    localparam logic [CNT_W-1:0]  CNT_TOP   = `QRECIP_SHIFT;
    localparam logic [PROD_W-1:0] ROUND     = PROD_W'(1) << (`QRECIP_SHIFT - 1);
    localparam logic [`LEVEL_WIDTH-1:0] LEVEL_MAX = {1'b0, {(`LEVEL_WIDTH-1){1'b1}}};

    // ---------------------------------------
    // Restoring divider for 2^17 / step
    // ---------------------------------------
    qstep_t                  step_q;
    qrecip_t                 recip_q;
    logic [`QSTEP_WIDTH-1:0] rem_q;
    logic [CNT_W-1:0]        cnt_q;
    logic                    busy_q;
    logic                    ready_q;
    logic [`QSTEP_WIDTH:0]   rem_shift;
    logic [`QSTEP_WIDTH:0]   rem_diff;
    logic                    take;

    // Only the top dividend bit is set
    assign rem_shift = {rem_q, (cnt_q == CNT_TOP)};
    assign take      = rem_shift >= {1'b0, step_q};
    assign rem_diff  = rem_shift - {1'b0, step_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q  <= '0;
            recip_q <= '0;
            rem_q   <= '0;
            cnt_q   <= '0;
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
        end else if (q_load_i) begin
            step_q  <= q_step_i;
            rem_q   <= '0;
            cnt_q   <= CNT_TOP;
            busy_q  <= 1'b1;
            ready_q <= 1'b0;
        end else if (busy_q) begin
            recip_q <= {recip_q[`QRECIP_SHIFT-1:0], take};  // One quotient bit per cycle
            rem_q   <= take ? rem_diff[`QSTEP_WIDTH-1:0] : rem_shift[`QSTEP_WIDTH-1:0];
            cnt_q   <= cnt_q - 1'b1;
            if (cnt_q == '0) begin
                busy_q  <= 1'b0;
                ready_q <= 1'b1;
            end
        end
    end

    assign q_ready_o = ready_q;

    // ---------------------------------------
    // Multiply, round, shift, saturate
    // ---------------------------------------
    level_t lvl_nxt [0:`WHT_NUM_COEF-1];

    for (genvar k = 0; k < `WHT_NUM_COEF; k++) begin : g_lane
        logic                               neg;
        logic [`WHT_WIDTH-1:0]              mag;    // |x| up to 16384
        logic [PROD_W-1:0]                  prod;
        logic [PROD_W-`QRECIP_SHIFT-1:0]    lvl_mag;
        logic [`LEVEL_WIDTH-1:0]            sat;

        assign neg     = block_i[k][`WHT_WIDTH-1];
        assign mag     = neg ? -block_i[k] : block_i[k];
        assign prod    = PROD_W'(mag) * PROD_W'(recip_q) + ROUND;
        assign lvl_mag = prod[PROD_W-1:`QRECIP_SHIFT];
        assign sat     = (lvl_mag > PROD_W'(LEVEL_MAX)) ? LEVEL_MAX
                                                        : lvl_mag[`LEVEL_WIDTH-1:0];
        assign lvl_nxt[k] = neg ? -sat : sat;   // Restore the sign
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            for (int i = 0; i < `WHT_NUM_COEF; i++) begin
                levels_o[i] <= '0;
            end
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                levels_o <= lvl_nxt;
            end
        end
    end

    // Upstream must not send blocks while the reciprocal is rebuilt
    a_no_block_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
        busy_q |-> !valid_i);

    a_step_nonzero : assert property (@(posedge clk) disable iff (!rst_n)
        q_load_i |-> (q_step_i != '0));

endmodule

// ==== luma_dc_top.sv ====
//--------------------------------------
// Luma DC path, collector to WHT to quantizer
// Levels appear three cycles after the 16th DC strobe
//--------------------------------------
`timescale 1ns/1ns

module luma_dc_top
    import coef_pkg::*, quant_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         dc_valid_i,
    input  dc_coef_t     dc_i,
    input  logic         q_load_i,
    input  qstep_t       q_step_i,
    output logic         q_ready_o,
    output logic         levels_valid_o,
    output level_block_t levels_o
);

    logic       blk_start;
    dc_block_t  blk_dc;
    logic       wht_done;
    wht_block_t wht_out;

    // Stage 1 gathers one block
    dc_collector u_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .dc_valid_i (dc_valid_i),
        .dc_i       (dc_i),
        .start_o    (blk_start),
        .block_o    (blk_dc)
    );

    // Stage 2
    wht_fwd u_wht (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (blk_start),
        .block_i (blk_dc),
        .done_o  (wht_done),
        .block_o (wht_out)
    );

    // Stage 3 with the step reciprocal
    dc_quantizer u_quant (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_load_i  (q_load_i),
        .q_step_i  (q_step_i),
        .q_ready_o (q_ready_o),
        .valid_i   (wht_done),
        .block_i   (wht_out),
        .valid_o   (levels_valid_o),
        .levels_o  (levels_o)
    );

endmodule

// ==== tb_luma_dc.sv ====
//--------------------------------------
// Testbench for the luma DC path
// Directed, random and gapped blocks checked against reference models
//--------------------------------------
`timescale 1ns/1ns
`include "wht_defs.svh"

module tb_luma_dc
    import coef_pkg::*, quant_pkg::*;
();

    localparam int NUM_BLOCKS      = 8 + 5 * 20 + 10;
    localparam int NUM_LOADS       = 7;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 20 + NUM_LOADS * 40 + 100;
    localparam qstep_t STEP_LIST [0:4] = '{8'd1, 8'd3, 8'd10, 8'd127, 8'd255};

    logic         clk = 1'b0;
    logic         rst_n;
    logic         dc_valid_i;
    dc_coef_t     dc_i;
    logic         q_load_i;
    qstep_t       q_step_i;
    logic         q_ready_o;
    logic         levels_valid_o;
    level_block_t levels_o;

    int           seed = 32'hd5e5_c443;
    string        test_name = "reset";
    qstep_t       cur_step;
    level_t       exp_lvl_q [$];        // Sixteen entries per block
    int           exp_edge_q [$];
    int           edge_cnt = 0;
    int           strobe_pos = 0;
    int           blocks_sent = 0;
    int           levels_seen = 0;
    dc_block_t    mon_blk;
    wht_block_t   mon_wht;
    level_block_t mon_lvl;

    luma_dc_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dc_valid_i     (dc_valid_i),
        .dc_i           (dc_i),
        .q_load_i       (q_load_i),
        .q_step_i       (q_step_i),
        .q_ready_o      (q_ready_o),
        .levels_valid_o (levels_valid_o),
        .levels_o       (levels_o)
    );

    always #4 clk = ~clk;

    // ---------------------------------------
    // Reference models
    // ---------------------------------------
    function automatic void ref_wht(input dc_block_t x, output wht_block_t y);
        int t [0:15];
        int a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            a0 = x[4*r+0] + x[4*r+2];
            a1 = x[4*r+1] + x[4*r+3];
            a2 = x[4*r+1] - x[4*r+3];
            a3 = x[4*r+0] - x[4*r+2];
            t[4*r+0] = a0 + a1;
            t[4*r+1] = a3 + a2;
            t[4*r+2] = a3 - a2;
            t[4*r+3] = a0 - a1;
        end
        for (int c = 0; c < 4; c++) begin
            a0 = t[c] + t[8+c];
            a1 = t[4+c] + t[12+c];
            a2 = t[4+c] - t[12+c];
            a3 = t[c] - t[8+c];
            y[c]    = wht_coef_t'((a0 + a1) >>> 1);     // Floor of half
            y[4+c]  = wht_coef_t'((a3 + a2) >>> 1);
            y[8+c]  = wht_coef_t'((a3 - a2) >>> 1);
            y[12+c] = wht_coef_t'((a0 - a1) >>> 1);
        end
    endfunction

    function automatic void ref_quant(input wht_block_t w, input qstep_t step,
                                      output level_block_t lv);
        longint recip;
        longint mag;
        longint lvl;
        recip = (longint'(1) << `QRECIP_SHIFT) / longint'(step);
        for (int k = 0; k < 16; k++) begin
            mag = (w[k] < 0) ? -longint'(w[k]) : longint'(w[k]);
            lvl = (mag * recip + (longint'(1) << (`QRECIP_SHIFT - 1))) >> `QRECIP_SHIFT;
            if (lvl > 2047) begin
                lvl = 2047;
            end
            lv[k] = level_t'((w[k] < 0) ? -lvl : lvl);
        end
    endfunction

    // ---------------------------------------
    // Compare tasks
    // ---------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_level(input string name, input int lane,
                               input level_t exp, input level_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s lane %0d expected %0d actual %0d",
                                name, lane, exp, act));
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s q_ready_o expected %b actual %b",
                                name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("** Error: %s levels edge expected %0d actual %0d",
                                name, exp, act));
        end
    endtask

    // ---------------------------------------
    // Stimulus
    // ---------------------------------------
    task automatic load_step(input qstep_t step);
        int cycles;
        @(posedge clk);
        q_load_i <= 1'b1;
        q_step_i <= step;
        @(posedge clk);
        q_load_i <= 1'b0;
        cur_step = step;                        // Pipeline is empty here
        @(negedge clk);
        check_ready({test_name, " load"}, 1'b0, q_ready_o);
        cycles = 0;
        while (!q_ready_o && cycles < 18) begin
            @(negedge clk);
            cycles++;
        end
        check_ready({test_name, " ready"}, 1'b1, q_ready_o);
    endtask

    task automatic send_block(input dc_block_t blk, input int max_gap);
        int gap;
        for (int i = 0; i < 16; i++) begin
            gap = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
            repeat (gap) begin
                @(posedge clk);
                dc_valid_i <= 1'b0;
            end
            @(posedge clk);
            dc_valid_i <= 1'b1;
            dc_i       <= blk[i];
        end
    endtask

    // Ends a stream and waits until every block has come out
    task automatic end_stream();
        @(posedge clk);
        dc_valid_i <= 1'b0;
        @(negedge clk);
        while (exp_edge_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic random_block(output dc_block_t blk);
        for (int i = 0; i < 16; i++) begin
            blk[i] = dc_coef_t'($random(seed));
        end
    endtask

    task automatic fill_block(output dc_block_t blk, input dc_coef_t v);
        for (int i = 0; i < 16; i++) begin
            blk[i] = v;
        end
    endtask

    // Builds the expected levels from what was driven
    always @(posedge clk) begin : monitor
        edge_cnt = edge_cnt + 1;
        if (dc_valid_i) begin
            mon_blk[strobe_pos] = dc_i;
            if (strobe_pos == `WHT_NUM_COEF - 1) begin
                ref_wht(mon_blk, mon_wht);
                ref_quant(mon_wht, cur_step, mon_lvl);
                for (int k = 0; k < 16; k++) begin
                    exp_lvl_q.push_back(mon_lvl[k]);
                end
                exp_edge_q.push_back(edge_cnt + 2);  // Three edges after launch
                blocks_sent++;
                strobe_pos = 0;
            end else begin
                strobe_pos++;
            end
        end
    end

    always @(negedge clk) begin : compare
        level_t exp_lvl;
        int     exp_edge;
        if (rst_n && levels_valid_o) begin
            if (exp_edge_q.size() == 0) begin
                abort_run("levels_valid_o pulsed with no block outstanding");
            end else begin
                exp_edge = exp_edge_q.pop_front();
                check_latency(test_name, exp_edge, edge_cnt);
                for (int k = 0; k < 16; k++) begin
                    exp_lvl = exp_lvl_q.pop_front();
                    check_level(test_name, k, exp_lvl, levels_o[k]);
                end
                check_ready(test_name, 1'b1, q_ready_o);
                levels_seen++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout waiting for levels");
    end

    initial begin : main
        dc_block_t blk;
        rst_n      = 1'b0;
        dc_valid_i = 1'b0;
        dc_i       = '0;
        q_load_i   = 1'b0;
        q_step_i   = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ready(test_name, 1'b0, q_ready_o);
        if (levels_valid_o !== 1'b0) begin
            abort_run("levels_valid_o was high straight after reset");
        end

        test_name = "directed_latency";
        load_step(8'd1);
        fill_block(blk, dc_coef_t'(0));
        send_block(blk, 0);
        blk[5] = dc_coef_t'(7);                 // Odd sums exercise halving
        send_block(blk, 0);
        fill_block(blk, dc_coef_t'(0));
        blk[0] = dc_coef_t'(-1);
        send_block(blk, 0);
        fill_block(blk, dc_coef_t'(100));
        send_block(blk, 0);
        fill_block(blk, dc_coef_t'(-3));
        send_block(blk, 0);
        fill_block(blk, dc_coef_t'(2047));
        send_block(blk, 0);
        fill_block(blk, dc_coef_t'(-2048));
        send_block(blk, 0);
        for (int i = 0; i < 16; i++) begin     // Checkerboard of extremes
            blk[i] = (((i / 4) + (i % 4)) % 2 == 0) ? dc_coef_t'(2047) : dc_coef_t'(-2048);
        end
        send_block(blk, 0);
        end_stream();

        for (int s = 0; s < 5; s++) begin
            test_name = $sformatf("random_step%0d", STEP_LIST[s]);
            load_step(STEP_LIST[s]);
            repeat (20) begin
                random_block(blk);
                send_block(blk, 0);
            end
            end_stream();
        end

        test_name = "gapped";
        load_step(8'd10);
        repeat (10) begin
            random_block(blk);
            send_block(blk, 2);
        end
        end_stream();

        repeat (5) @(negedge clk);
        if (levels_seen == blocks_sent && blocks_sent == NUM_BLOCKS) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d level pulses seen for %0d blocks sent",
                                levels_seen, blocks_sent));
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
coef_pkg.sv
quant_pkg.sv
dc_collector.sv
wht_fwd.sv
dc_quantizer.sv
luma_dc_top.sv
tb_luma_dc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the luma DC testbench with Verilator and runs it
# The exit status of the simulation is the pass or fail result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_luma_dc \
    -Mdir obj_dir \
    -o sim_luma_dc

./obj_dir/sim_luma_dc
